//--- source/core_pkg.sv
//----------------------------------------------------------------------
// shared widths, RV32 opcode/funct constants and the ALU operation enum
//----------------------------------------------------------------------

package core_pkg;

    // data and address width
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // ALU operations, pass-b carries the LUI immediate through
    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_xor    = 3'd4,
        alu_pass_b = 3'd5
    } alu_op_e;

    //------------------------------------------------------------------
    // major opcodes
    //------------------------------------------------------------------
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;

    //------------------------------------------------------------------
    // funct3 values of the supported subset
    //------------------------------------------------------------------
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // instruction bit that turns ADD into SUB
    localparam int f7_sub_bit = 30;

endpackage

//--- source/instr_fetch.sv
//----------------------------------------------------------------------
// instruction fetch: PC, req/gnt sequencing, fetched word register
//----------------------------------------------------------------------

`timescale 1ns/10ps

module instr_fetch
    import core_pkg::*;
#(
    parameter word_t boot_addr = '0
) (
    input  logic  clk,
    input  logic  arst_n,
    output logic  instr_req,
    output word_t instr_addr,
    input  logic  instr_gnt,
    input  word_t instr_data,
    output logic  instr_valid,
    output word_t instr_word,
    output word_t instr_pc
);

    word_t pc;
    logic  req_q;
    logic  fetch_done;

    // a fetch completes on the first granted request cycle
    assign fetch_done = req_q & instr_gnt;

    assign instr_req  = req_q;
    assign instr_addr = pc;

    //------------------------------------------------------------------
    // request state and program counter
    //------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_q       <= 1'b0;
            instr_valid <= 1'b0;
            pc          <= boot_addr;
        end else begin
            // drop the request for one cycle after a grant
            req_q       <= ~fetch_done;
            instr_valid <= fetch_done;
            if (fetch_done) begin
                pc <= pc + xlen'(4);
            end
        end
    end

    //------------------------------------------------------------------
    // fetched word and its address
    //------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (fetch_done) begin
            instr_word <= instr_data;
            instr_pc   <= pc;
        end
    end

endmodule

//--- source/reg_file.sv
//----------------------------------------------------------------------
// integer register file, two async read ports and one write port
//----------------------------------------------------------------------

`timescale 1ns/10ps

module reg_file
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     wb_en,
    input  reg_idx_t wb_idx,
    input  word_t    wb_data
);

    // x1..x31, x0 is not stored
    word_t regs [1:31];

    //------------------------------------------------------------------
    // write port
    //------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_idx != '0)) begin
            regs[wb_idx] <= wb_data;
        end
    end

    //------------------------------------------------------------------
    // read ports
    //------------------------------------------------------------------
    // no bypass, a write never lands in the cycle of a dependent read
    always_comb begin
        rs1_data = '0;
        rs2_data = '0;
        if (rs1_idx != '0) begin
            rs1_data = regs[rs1_idx];
        end
        if (rs2_idx != '0) begin
            rs2_data = regs[rs2_idx];
        end
    end

endmodule

//--- source/instr_decode.sv
//----------------------------------------------------------------------
// decoder for the ALU subset: fields, immediate, ALU op, illegal flag
//----------------------------------------------------------------------

`timescale 1ns/10ps

module instr_decode
    import core_pkg::*;
(
    input  word_t    instr_word,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    output reg_idx_t rd_idx,
    output word_t    imm,
    output alu_op_e  alu_op,
    output logic     use_imm,
    output logic     write_en,
    output logic     illegal
);

    localparam logic [6:0] f7_sub_mask = 7'(1 << (f7_sub_bit - 25));

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_sub;
    logic       f7_other;

    assign opcode   = instr_word[6:0];
    assign funct3   = instr_word[14:12];
    assign funct7   = instr_word[31:25];
    assign f7_sub   = instr_word[f7_sub_bit];
    // any funct7 bit besides the sub selector makes an OP word illegal
    assign f7_other = (funct7 & ~f7_sub_mask) != '0;

    assign rs1_idx = instr_word[19:15];
    assign rs2_idx = instr_word[24:20];
    assign rd_idx  = instr_word[11:7];

    always_comb begin
        alu_op   = alu_add;
        use_imm  = 1'b0;
        write_en = 1'b0;
        illegal  = 1'b1;
        // I-type immediate by default
        imm      = {{(xlen-12){instr_word[31]}}, instr_word[31:20]};

        case (opcode)
            opc_op: begin
                if (!f7_other) begin
                    illegal = 1'b0;
                    case (funct3)
                        f3_add_sub: alu_op = f7_sub ? alu_sub : alu_add;
                        f3_xor:     alu_op = alu_xor;
                        f3_or:      alu_op = alu_or;
                        f3_and:     alu_op = alu_and;
                        default:    illegal = 1'b1;
                    endcase
                    // sub bit only means something for add/sub
                    if (f7_sub && (funct3 != f3_add_sub)) begin
                        illegal = 1'b1;
                    end
                end
            end
            opc_op_imm: begin
                use_imm = 1'b1;
                illegal = 1'b0;
                case (funct3)
                    f3_add_sub: alu_op = alu_add;
                    f3_xor:     alu_op = alu_xor;
                    f3_or:      alu_op = alu_or;
                    f3_and:     alu_op = alu_and;
                    default:    illegal = 1'b1;
                endcase
            end
            opc_lui: begin
                alu_op  = alu_pass_b;
                use_imm = 1'b1;
                illegal = 1'b0;
                imm     = {instr_word[31:12], 12'b0};
            end
            default: begin
                illegal = 1'b1;
            end
        endcase

        write_en = ~illegal;
    end

endmodule

//--- source/execute_stage.sv
//----------------------------------------------------------------------
// execute stage: operand select, ALU, writeback and retirement trace
//----------------------------------------------------------------------

`timescale 1ns/10ps

module execute_stage
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     instr_valid,
    input  word_t    instr_pc,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    input  word_t    imm,
    input  alu_op_e  alu_op,
    input  logic     use_imm,
    input  logic     write_en,
    input  logic     illegal,
    input  reg_idx_t rd_idx,
    output logic     wb_en,
    output reg_idx_t wb_idx,
    output word_t    wb_data,
    output logic     retire_valid,
    output word_t    retire_pc,
    output reg_idx_t retire_rd,
    output word_t    retire_data,
    output logic     retire_we,
    output logic     retire_illegal
);

    word_t op_b;
    word_t alu_result;

    //------------------------------------------------------------------
    // ALU
    //------------------------------------------------------------------
    assign op_b = use_imm ? imm : rs2_data;

    always_comb begin
        case (alu_op)
            alu_add:    alu_result = rs1_data + op_b;
            alu_sub:    alu_result = rs1_data - op_b;
            alu_and:    alu_result = rs1_data & op_b;
            alu_or:     alu_result = rs1_data | op_b;
            alu_xor:    alu_result = rs1_data ^ op_b;
            alu_pass_b: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    // register file takes the result at the end of the valid cycle
    assign wb_en   = instr_valid & write_en;
    assign wb_idx  = rd_idx;
    assign wb_data = alu_result;

    //------------------------------------------------------------------
    // retirement trace
    //------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_valid   <= 1'b0;
            retire_we      <= 1'b0;
            retire_illegal <= 1'b0;
        end else begin
            retire_valid   <= instr_valid;
            // x0 writes are not architectural
            retire_we      <= wb_en & (rd_idx != '0);
            retire_illegal <= instr_valid & illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            retire_pc   <= instr_pc;
            retire_rd   <= rd_idx;
            retire_data <= write_en ? alu_result : '0;
        end
    end

endmodule

//--- source/rv_core.sv
//----------------------------------------------------------------------
// RV32 ALU-subset core top: fetch, decode, register file, execute
//----------------------------------------------------------------------

`timescale 1ns/10ps

module rv_core
    import core_pkg::*;
#(
    parameter word_t boot_addr = '0
) (
    input  logic     clk,
    input  logic     arst_n,
    output logic     instr_req,
    output word_t    instr_addr,
    input  logic     instr_gnt,
    input  word_t    instr_data,
    output logic     retire_valid,
    output word_t    retire_pc,
    output reg_idx_t retire_rd,
    output word_t    retire_data,
    output logic     retire_we,
    output logic     retire_illegal
);

    // fetch to decode/execute
    logic     instr_valid;
    word_t    instr_word;
    word_t    instr_pc;

    // decode outputs
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    reg_idx_t rd_idx;
    word_t    imm;
    alu_op_e  alu_op;
    logic     use_imm;
    logic     write_en;
    logic     illegal;

    // register file paths
    word_t    rs1_data;
    word_t    rs2_data;
    logic     wb_en;
    reg_idx_t wb_idx;
    word_t    wb_data;

    instr_fetch #(
        .boot_addr(boot_addr)
    ) u_fetch (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr_req  (instr_req),
        .instr_addr (instr_addr),
        .instr_gnt  (instr_gnt),
        .instr_data (instr_data),
        .instr_valid(instr_valid),
        .instr_word (instr_word),
        .instr_pc   (instr_pc)
    );

    instr_decode u_decode (
        .instr_word(instr_word),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .rd_idx    (rd_idx),
        .imm       (imm),
        .alu_op    (alu_op),
        .use_imm   (use_imm),
        .write_en  (write_en),
        .illegal   (illegal)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wb_en   (wb_en),
        .wb_idx  (wb_idx),
        .wb_data (wb_data)
    );

    execute_stage u_execute (
        .clk           (clk),
        .arst_n        (arst_n),
        .instr_valid   (instr_valid),
        .instr_pc      (instr_pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .imm           (imm),
        .alu_op        (alu_op),
        .use_imm       (use_imm),
        .write_en      (write_en),
        .illegal       (illegal),
        .rd_idx        (rd_idx),
        .wb_en         (wb_en),
        .wb_idx        (wb_idx),
        .wb_data       (wb_data),
        .retire_valid  (retire_valid),
        .retire_pc     (retire_pc),
        .retire_rd     (retire_rd),
        .retire_data   (retire_data),
        .retire_we     (retire_we),
        .retire_illegal(retire_illegal)
    );

endmodule

//--- verification/imem_model.sv
//----------------------------------------------------------------------
// testbench instruction memory, grants one cycle after a request
//----------------------------------------------------------------------

`timescale 1ns/10ps

module imem_model
    import core_pkg::*;
#(
    parameter int depth = 512
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  stall,
    input  logic  instr_req,
    input  word_t instr_addr,
    output logic  instr_gnt,
    output word_t instr_data
);

    // loaded by the testbench while the core is in reset
    word_t mem [0:depth-1];

    // one grant per request, none while stalled
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr_gnt  <= 1'b0;
            instr_data <= '0;
        end else begin
            instr_gnt  <= instr_req & ~instr_gnt & ~stall;
            instr_data <= mem[instr_addr[$clog2(depth)+1:2]];
        end
    end

endmodule

//--- verification/tb_rv_core.sv
//----------------------------------------------------------------------
// testbench for rv_core: program generation, ISA model, trace checks
//----------------------------------------------------------------------

`timescale 1ns/10ps

module tb_rv_core
    import core_pkg::*;
;

    localparam word_t boot_addr = '0;
    localparam int mem_depth = 512;
    localparam int max_stall = 4;
    localparam int mix_len   = 200;
    localparam int ill_len   = 60;
    localparam int lat_len   = 16;
    localparam logic [2:0] f3_list [4] = '{f3_add_sub, f3_xor, f3_or, f3_and};

    logic     clk    = 1'b0;
    logic     arst_n = 1'b0;
    logic     stall  = 1'b1;
    logic     instr_req;
    word_t    instr_addr;
    logic     instr_gnt;
    word_t    instr_data;
    logic     retire_valid;
    word_t    retire_pc;
    reg_idx_t retire_rd;
    word_t    retire_data;
    logic     retire_we;
    logic     retire_illegal;

    // program and reference model state
    word_t prog [$];
    word_t model_regs [32];
    // last value the trace showed for each register
    word_t last_wr [32];
    word_t exp_pc;
    int    grant_cycle [$];
    int    grant_cnt   = 0;
    int    retire_cnt  = 0;
    int    n_prog      = 0;
    int    cycle_cnt   = 0;
    int    cycle_limit = 0;
    int    stall_run   = 0;
    logic  stall_rand  = 1'b0;
    string test_name   = "reset";

    rv_core #(
        .boot_addr(boot_addr)
    ) u_rv_core (
        .clk           (clk),
        .arst_n        (arst_n),
        .instr_req     (instr_req),
        .instr_addr    (instr_addr),
        .instr_gnt     (instr_gnt),
        .instr_data    (instr_data),
        .retire_valid  (retire_valid),
        .retire_pc     (retire_pc),
        .retire_rd     (retire_rd),
        .retire_data   (retire_data),
        .retire_we     (retire_we),
        .retire_illegal(retire_illegal)
    );

    imem_model #(
        .depth(mem_depth)
    ) u_imem (
        .clk       (clk),
        .arst_n    (arst_n),
        .stall     (stall),
        .instr_req (instr_req),
        .instr_addr(instr_addr),
        .instr_gnt (instr_gnt),
        .instr_data(instr_data)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    //------------------------------------------------------------------
    // failure reporting and compare tasks
    //------------------------------------------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (exp !== act) begin
            report_failure($sformatf("FAIL %s %s: expected %h actual %h",
                                     test_name, what, exp, act));
        end
    endtask

    task automatic check_reg(input string what, input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act) begin
            report_failure($sformatf("FAIL %s %s: expected x%0d actual x%0d",
                                     test_name, what, exp, act));
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            report_failure($sformatf("FAIL %s %s: expected %b actual %b",
                                     test_name, what, exp, act));
        end
    endtask

    //------------------------------------------------------------------
    // instruction builders
    //------------------------------------------------------------------
    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd);
        return {imm, rs1, f3, rd, opc_op_imm};
    endfunction

    // kinds 0-3 OP, 4 SUB, 5-8 OP-IMM, 9 LUI
    function automatic word_t rand_instr();
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        int       kind;
        rd   = 5'($urandom_range(0, 31));
        rs1  = 5'($urandom_range(0, 31));
        rs2  = 5'($urandom_range(0, 31));
        kind = $urandom_range(0, 9);
        if (kind < 4) begin
            return enc_r(7'b0000000, rs2, rs1, f3_list[kind], rd);
        end
        if (kind == 4) begin
            return enc_r(7'b0100000, rs2, rs1, f3_add_sub, rd);
        end
        if (kind < 9) begin
            return enc_i(12'($urandom()), rs1, f3_list[kind-5], rd);
        end
        return {20'($urandom()), rd, opc_lui};
    endfunction

    function automatic word_t illegal_word();
        word_t w;
        do begin
            w = $urandom();
        end while (w[6:0] inside {opc_op, opc_op_imm, opc_lui});
        return w;
    endfunction

    //------------------------------------------------------------------
    // reference model built from the ISA encoding
    //------------------------------------------------------------------
    task automatic model_exec(input word_t w, output reg_idx_t rd, output logic we,
                              output logic ill, output word_t data);
        word_t      a;
        word_t      b;
        logic [2:0] f3;
        logic       is_op;
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        f3    = w[14:12];
        rd    = w[11:7];
        is_op = (w[6:0] == opc_op);
        ill   = 1'b0;
        data  = '0;
        if (w[6:0] == opc_lui) begin
            data = {w[31:12], 12'h000};
        end else if (is_op || w[6:0] == opc_op_imm) begin
            if (is_op) begin
                ill = !(w[31:25] == 7'b0000000 ||
                        (w[31:25] == 7'b0100000 && f3 == f3_add_sub));
            end else begin
                b = {{20{w[31]}}, w[31:20]};
            end
            case (f3)
                f3_add_sub: data = (is_op && w[30]) ? a - b : a + b;
                f3_xor:     data = a ^ b;
                f3_or:      data = a | b;
                f3_and:     data = a & b;
                default:    ill = 1'b1;
            endcase
        end else begin
            ill = 1'b1;
        end
        we = !ill && (rd != 5'd0);
    endtask

    task automatic check_retire();
        word_t    w;
        reg_idx_t rd;
        logic     we;
        logic     ill;
        word_t    data;
        int       gnt_at;
        if (grant_cycle.size() == 0 || retire_cnt >= n_prog) begin
            report_failure($sformatf("%s: instruction retired without a granted fetch",
                                     test_name));
        end
        gnt_at = grant_cycle.pop_front();
        if (cycle_cnt - gnt_at != 2) begin
            report_failure($sformatf("FAIL %s grant to retire latency: expected 2 actual %0d",
                                     test_name, cycle_cnt - gnt_at));
        end
        w = prog[retire_cnt];
        model_exec(w, rd, we, ill, data);
        check_word("retire_pc", exp_pc, retire_pc);
        check_reg("retire_rd", rd, retire_rd);
        check_flag("retire_illegal", ill, retire_illegal);
        check_flag("retire_we", we, retire_we);
        if (!ill) begin
            check_word("retire_data", data, retire_data);
        end
        if (we) begin
            model_regs[rd] = data;
        end
        if (retire_we) begin
            last_wr[retire_rd] = retire_data;
        end
        exp_pc = exp_pc + 32'd4;
        retire_cnt++;
    endtask

    //------------------------------------------------------------------
    // trace monitor sampled mid-cycle
    //------------------------------------------------------------------
    always @(negedge clk) begin
        if (!arst_n) begin
            grant_cnt  = 0;
            retire_cnt = 0;
            grant_cycle.delete();
            exp_pc = boot_addr;
            foreach (model_regs[i]) begin
                model_regs[i] = '0;
                last_wr[i]    = '0;
            end
        end else begin
            if (retire_valid) begin
                check_retire();
            end
            if (instr_req && instr_gnt) begin
                grant_cnt++;
                grant_cycle.push_back(cycle_cnt);
            end
        end
    end

    // cycle count, timeout and grant stalls
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            report_failure($sformatf("timeout: the run did not finish within %0d cycles",
                                     cycle_limit));
        end
        if (grant_cnt >= n_prog) begin
            // stop answering once the whole program is granted
            stall <= 1'b1;
        end else if (stall_rand && stall_run < max_stall - 1 &&
                     $urandom_range(0, 1) == 1) begin
            stall     <= 1'b1;
            stall_run <= stall_run + 1;
        end else begin
            stall     <= 1'b0;
            stall_run <= 0;
        end
    end

    //------------------------------------------------------------------
    // test sequencing
    //------------------------------------------------------------------
    task automatic run_program(input string name, input logic with_stalls);
        @(posedge clk);
        arst_n <= 1'b0;
        @(negedge clk);
        test_name  = name;
        stall_rand = with_stalls;
        n_prog     = prog.size();
        for (int i = 0; i < mem_depth; i++) begin
            u_imem.mem[i] = (i < n_prog) ? prog[i] : ~word_t'(i);
        end
        check_flag("instr_req in reset", 1'b0, instr_req);
        check_flag("retire_valid in reset", 1'b0, retire_valid);
        check_flag("retire_we in reset", 1'b0, retire_we);
        check_word("instr_addr in reset", boot_addr, instr_addr);
        repeat (5) begin
            @(posedge clk);
        end
        arst_n <= 1'b1;
        do begin
            @(negedge clk);
        end while (!instr_req);
        check_word("first instr_addr", boot_addr, instr_addr);
        while (retire_cnt < n_prog) begin
            @(negedge clk);
        end
    endtask

    initial begin
        int    dbl_n;
        int    fib_n;
        int    total;
        word_t fa;
        word_t fb;
        word_t fc;
        word_t mix_prog [$];
        void'($urandom(63358));
        dbl_n       = $urandom_range(1, 31);
        fib_n       = $urandom_range(1, 32);
        total       = (1 + dbl_n) + (2 + 3 * fib_n) + 2 * mix_len + ill_len + lat_len;
        cycle_limit = 4 * total * max_stall + 200;

        // doubler
        prog.delete();
        prog.push_back(enc_i(12'd1, 5'd0, f3_add_sub, 5'd1));
        repeat (dbl_n) begin
            prog.push_back(enc_r(7'b0000000, 5'd1, 5'd1, f3_add_sub, 5'd1));
        end
        run_program("doubler", 1'b0);
        check_word("final x1", word_t'(1) << dbl_n, last_wr[1]);

        // fibonacci where x3 = x1 + x2 and the pair shifts down
        prog.delete();
        prog.push_back(enc_i(12'd0, 5'd0, f3_add_sub, 5'd1));
        prog.push_back(enc_i(12'd1, 5'd0, f3_add_sub, 5'd2));
        repeat (fib_n) begin
            prog.push_back(enc_r(7'b0000000, 5'd2, 5'd1, f3_add_sub, 5'd3));
            prog.push_back(enc_i(12'd0, 5'd2, f3_add_sub, 5'd1));
            prog.push_back(enc_i(12'd0, 5'd3, f3_add_sub, 5'd2));
        end
        run_program("fibonacci", 1'b0);
        fa = '0;
        fb = 32'd1;
        fc = '0;
        repeat (fib_n) begin
            fc = fa + fb;
            fa = fb;
            fb = fc;
        end
        check_word("final x1", fa, last_wr[1]);
        check_word("final x2", fb, last_wr[2]);
        check_word("final x3", fc, last_wr[3]);

        repeat (mix_len) begin
            mix_prog.push_back(rand_instr());
        end
        prog = mix_prog;
        run_program("random_mix", 1'b0);

        // roughly one word in three is outside the subset
        prog.delete();
        repeat (ill_len) begin
            if ($urandom_range(0, 2) == 0) begin
                prog.push_back(illegal_word());
            end else begin
                prog.push_back(rand_instr());
            end
        end
        run_program("illegal_words", 1'b0);

        prog = mix_prog;
        run_program("back_pressure", 1'b1);

        prog.delete();
        repeat (lat_len) begin
            prog.push_back(rand_instr());
        end
        run_program("reset_latency", 1'b0);

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- files.f
source/core_pkg.sv
source/instr_fetch.sv
source/reg_file.sv
source/instr_decode.sv
source/execute_stage.sv
source/rv_core.sv
verification/imem_model.sv
verification/tb_rv_core.sv

//--- run.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps \
    --top-module tb_rv_core \
    -f files.f \
    --Mdir obj_dir -o sim_rv_core
status=$?
if [ $status -ne 0 ]; then
    echo "build failed"
    exit $status
fi

./obj_dir/sim_rv_core
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0
